//--- Bender.yml
package:
  name: card_list

sources:
  - include_dirs:
      - hw
    files:
      - hw/card_pkg.sv
      - hw/card_ram.sv
      - hw/free_slot_finder.sv
      - hw/card_appender.sv
      - hw/card_remover.sv
      - hw/card_list_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/card_list_tb.sv

//--- files.f
+incdir+hw
hw/card_pkg.sv
hw/card_ram.sv
hw/free_slot_finder.sv
hw/card_appender.sv
hw/card_remover.sv
hw/card_list_top.sv
test/card_list_tb.sv

//--- hw/card_appender.sv
module card_appender (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  go,
    input  card_pkg::card_addr_t  head,
    input  card_pkg::card_value_t value,
    input  card_pkg::card_word_t  rdata,
    output card_pkg::ram_req_t    req,
    output logic                  busy,
    output logic                  done,
    output card_pkg::card_addr_t  new_addr
);

    card_pkg::appender_state_t state;
    card_pkg::card_addr_t      cur_addr;  // Node being read, the tail once found
    card_pkg::card_value_t     value_q;
    card_pkg::card_word_t      tail_word;
    logic                      rd_valid;  // rdata holds the word at cur_addr
    logic                      at_tail;
    logic                      finder_go;
    logic                      found;
    card_pkg::card_addr_t      slot_addr;
    card_pkg::ram_req_t        finder_req;

    assign busy      = (state != card_pkg::APP_IDLE);
    assign at_tail   = (state == card_pkg::APP_WALK) && rd_valid && (rdata.next == '0);
    assign finder_go = at_tail;

    free_slot_finder u_finder (
        .clock     (clock),
        .rst       (rst),
        .go        (finder_go),
        .rdata     (rdata),
        .req       (finder_req),
        .found     (found),
        .slot_addr (slot_addr)
    );

    always_comb begin
        req = '0;
        case (state)
            card_pkg::APP_WALK: req.addr = cur_addr;
            card_pkg::APP_ALLOC: req = finder_req; // Port lent to the scan
            card_pkg::APP_WR_CARD: begin
                req.addr        = new_addr;
                req.wdata.used  = 1'b1;
                req.wdata.value = value_q;
                req.wen         = 1'b1;
            end
            card_pkg::APP_WR_TAIL: begin
                req.addr       = cur_addr;
                req.wdata      = tail_word;
                req.wdata.next = new_addr; // Link the new card behind the tail
                req.wen        = 1'b1;
            end
            default: req = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state    <= card_pkg::APP_IDLE;
            rd_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                card_pkg::APP_IDLE: begin
                    rd_valid <= 1'b0;
                    if (go) begin
                        state <= card_pkg::APP_WALK;
                    end
                end
                card_pkg::APP_WALK: begin
                    rd_valid <= !rd_valid; // Present, then consume
                    if (at_tail) begin
                        state <= card_pkg::APP_ALLOC;
                    end
                end
                card_pkg::APP_ALLOC: begin
                    if (found) begin
                        state <= card_pkg::APP_WR_CARD;
                    end
                end
                card_pkg::APP_WR_CARD: state <= card_pkg::APP_WR_TAIL;
                card_pkg::APP_WR_TAIL: begin
                    state <= card_pkg::APP_IDLE;
                    done  <= 1'b1;
                end
                default: state <= card_pkg::APP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (go && (state == card_pkg::APP_IDLE)) begin
            cur_addr <= head; // Walk starts at the sentinel
            value_q  <= value;
        end else if ((state == card_pkg::APP_WALK) && rd_valid) begin
            if (rdata.next == '0) begin
                tail_word <= rdata;
            end else begin
                cur_addr <= rdata.next;
            end
        end
        if (found) begin
            new_addr <= slot_addr;
        end
    end

endmodule

//--- hw/card_defines.svh
`ifndef CARD_DEFINES_SVH
`define CARD_DEFINES_SVH

// Word format widths
`define CARD_ADDR_W    10 // Next-pointer and RAM address
`define CARD_VALUE_W   6  // Number and suit
`define CARD_INDEX_W   6  // Position within a list
`define CARD_WORD_W    32 // One RAM word

// Memory map
// Address 0 is the null pointer, 1 to 15 are list sentinels
`define CARD_HEAP_BASE 16   // First allocatable slot
`define CARD_RAM_DEPTH 1024 // Words in the RAM

`endif

//--- hw/card_list_top.sv
module card_list_top (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   start,
    input  card_pkg::card_cmd_t    cmd,
    output logic                   busy,
    output logic                   done,
    output card_pkg::card_result_t result
);

    logic                  accept;
    logic                  go_add;
    logic                  go_rem;
    logic                  app_busy;
    logic                  rem_busy;
    logic                  app_done;
    logic                  rem_done;
    card_pkg::card_addr_t  app_new_addr;
    card_pkg::card_value_t rem_value;
    card_pkg::ram_req_t    app_req;
    card_pkg::ram_req_t    rem_req;
    card_pkg::ram_req_t    ram_req;
    card_pkg::card_word_t  rdata;
    card_pkg::card_result_t result_q;

    assign busy   = app_busy | rem_busy;
    assign done   = app_done | rem_done;
    assign accept = start & ~busy; // Starts during an operation are dropped
    assign go_add = accept & (cmd.op == card_pkg::OP_ADD);
    assign go_rem = accept & (cmd.op == card_pkg::OP_REMOVE);

    // Only one controller runs at a time
    always_comb begin
        if (app_busy) begin
            ram_req = app_req;
        end else if (rem_busy) begin
            ram_req = rem_req;
        end else begin
            ram_req = '0;
        end
    end

    card_ram u_ram (
        .clock (clock),
        .req   (ram_req),
        .rdata (rdata)
    );

    card_appender u_appender (
        .clock    (clock),
        .rst      (rst),
        .go       (go_add),
        .head     (cmd.head),
        .value    (cmd.value),
        .rdata    (rdata),
        .req      (app_req),
        .busy     (app_busy),
        .done     (app_done),
        .new_addr (app_new_addr)
    );

    card_remover u_remover (
        .clock         (clock),
        .rst           (rst),
        .go            (go_rem),
        .head          (cmd.head),
        .n             (cmd.n),
        .rdata         (rdata),
        .req           (rem_req),
        .busy          (rem_busy),
        .done          (rem_done),
        .removed_value (rem_value)
    );

    always_ff @(posedge clock) begin
        if (app_done) begin
            result_q.new_addr <= app_new_addr;
        end
        if (rem_done) begin
            result_q.removed_value <= rem_value;
        end
    end

    // Fresh field shows in the done cycle, held register after that
    always_comb begin
        result = result_q;
        if (app_done) begin
            result.new_addr = app_new_addr;
        end
        if (rem_done) begin
            result.removed_value = rem_value;
        end
    end

endmodule

//--- hw/card_pkg.sv
`include "card_defines.svh"

package card_pkg;

    typedef logic [`CARD_ADDR_W-1:0]  card_addr_t;
    typedef logic [`CARD_VALUE_W-1:0] card_value_t;
    typedef logic [`CARD_INDEX_W-1:0] card_index_t;

    // One RAM word, top bit down
    typedef struct packed {
        logic        used;    // Slot holds a live card
        logic [8:0]  rsvd_hi;
        card_value_t value;
        logic [5:0]  rsvd_lo;
        card_addr_t  next;    // Zero ends the list
    } card_word_t;

    typedef struct packed {
        card_addr_t addr;
        card_word_t wdata;
        logic       wen;
    } ram_req_t;

    typedef enum logic {
        OP_ADD    = 1'b0,
        OP_REMOVE = 1'b1
    } card_op_t;

    typedef struct packed {
        card_op_t    op;
        card_addr_t  head;  // Sentinel address of the list
        card_value_t value; // Card to append
        card_index_t n;     // Position to remove
    } card_cmd_t;

    typedef struct packed {
        card_value_t removed_value;
        card_addr_t  new_addr;
    } card_result_t;

    typedef enum logic [2:0] {
        APP_IDLE,
        APP_WALK,
        APP_ALLOC,
        APP_WR_CARD,
        APP_WR_TAIL
    } appender_state_t;

    typedef enum logic [2:0] {
        REM_IDLE,
        REM_WALK,
        REM_TARGET,
        REM_WR_PRED,
        REM_WR_TARGET
    } remover_state_t;

    typedef enum logic {
        FIND_IDLE,
        FIND_SCAN
    } finder_state_t;

endpackage

//--- hw/card_ram.sv
`include "card_defines.svh"

module card_ram (
    input  logic                 clock,
    input  card_pkg::ram_req_t   req,
    output card_pkg::card_word_t rdata
);

    logic [`CARD_WORD_W-1:0] mem [`CARD_RAM_DEPTH];

    // All lists empty and every heap slot free at power-up
    initial begin
        for (int i = 0; i < `CARD_RAM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (req.wen) begin
            mem[req.addr] <= req.wdata;
        end
        rdata <= mem[req.addr]; // Old word on a same-cycle write
    end

endmodule

//--- hw/card_remover.sv
module card_remover (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  go,
    input  card_pkg::card_addr_t  head,
    input  card_pkg::card_index_t n,
    input  card_pkg::card_word_t  rdata,
    output card_pkg::ram_req_t    req,
    output logic                  busy,
    output logic                  done,
    output card_pkg::card_value_t removed_value
);

    card_pkg::remover_state_t state;
    card_pkg::card_addr_t     cur_addr;  // Ends on the predecessor of card n
    card_pkg::card_index_t    count;     // Links still to follow
    card_pkg::card_word_t     pred_word;
    card_pkg::card_addr_t     tgt_addr;
    card_pkg::card_addr_t     tgt_next;
    logic                     rd_valid;  // rdata holds the word just addressed
    logic                     at_pred;
    logic                     tgt_read;

    assign busy     = (state != card_pkg::REM_IDLE);
    assign at_pred  = (state == card_pkg::REM_WALK) && rd_valid && (count == '0);
    assign tgt_read = (state == card_pkg::REM_TARGET) && rd_valid;

    always_comb begin
        req = '0;
        case (state)
            card_pkg::REM_WALK: req.addr = cur_addr;
            card_pkg::REM_TARGET: req.addr = tgt_addr;
            card_pkg::REM_WR_PRED: begin
                req.addr       = cur_addr;
                req.wdata      = pred_word;
                req.wdata.next = tgt_next; // Skip over the target
                req.wen        = 1'b1;
            end
            card_pkg::REM_WR_TARGET: begin
                req.addr = tgt_addr; // All-zero word frees the slot
                req.wen  = 1'b1;
            end
            default: req = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state    <= card_pkg::REM_IDLE;
            rd_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                card_pkg::REM_IDLE: begin
                    rd_valid <= 1'b0;
                    if (go) begin
                        state <= card_pkg::REM_WALK;
                    end
                end
                card_pkg::REM_WALK: begin
                    rd_valid <= !rd_valid;
                    if (at_pred) begin
                        state <= card_pkg::REM_TARGET;
                    end
                end
                card_pkg::REM_TARGET: begin
                    rd_valid <= !rd_valid;
                    if (tgt_read) begin
                        state <= card_pkg::REM_WR_PRED;
                    end
                end
                card_pkg::REM_WR_PRED: state <= card_pkg::REM_WR_TARGET;
                card_pkg::REM_WR_TARGET: begin
                    state <= card_pkg::REM_IDLE;
                    done  <= 1'b1;
                end
                default: state <= card_pkg::REM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (go && (state == card_pkg::REM_IDLE)) begin
            cur_addr <= head;
            count    <= n;
        end else if ((state == card_pkg::REM_WALK) && rd_valid) begin
            if (count == '0) begin
                pred_word <= rdata;
                tgt_addr  <= rdata.next;
            end else begin
                cur_addr <= rdata.next; // One link further
                count    <= count - card_pkg::card_index_t'(1);
            end
        end
        if (tgt_read) begin
            tgt_next      <= rdata.next;
            removed_value <= rdata.value;
        end
    end

endmodule

//--- hw/free_slot_finder.sv
`include "card_defines.svh"

module free_slot_finder (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 go,
    input  card_pkg::card_word_t rdata,
    output card_pkg::ram_req_t   req,
    output logic                 found,
    output card_pkg::card_addr_t slot_addr
);

    card_pkg::finder_state_t state;
    card_pkg::card_addr_t    scan_addr;   // Address presented this cycle
    card_pkg::card_addr_t    flight_addr; // Address whose word is on rdata
    logic                    flight_valid;
    logic                    hit;

    assign hit = (state == card_pkg::FIND_SCAN) && flight_valid && !rdata.used;

    always_comb begin
        req      = '0;
        req.addr = scan_addr; // Read only, never writes
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state        <= card_pkg::FIND_IDLE;
            found        <= 1'b0;
            flight_valid <= 1'b0;
        end else begin
            found <= 1'b0;
            case (state)
                card_pkg::FIND_IDLE: begin
                    flight_valid <= 1'b0;
                    if (go) begin
                        state <= card_pkg::FIND_SCAN;
                    end
                end
                card_pkg::FIND_SCAN: begin
                    if (hit) begin
                        state <= card_pkg::FIND_IDLE;
                        found <= 1'b1;
                    end else begin
                        flight_valid <= 1'b1; // First word lands one cycle late
                    end
                end
                default: state <= card_pkg::FIND_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == card_pkg::FIND_IDLE) begin
            scan_addr <= card_pkg::card_addr_t'(`CARD_HEAP_BASE);
        end else begin
            scan_addr   <= scan_addr + card_pkg::card_addr_t'(1);
            flight_addr <= scan_addr;
        end
        if (hit) begin
            slot_addr <= flight_addr; // Lowest free slot
        end
    end

endmodule

//--- test/card_list_tb.sv
`include "card_defines.svh"

module card_list_tb;

    localparam int num_ops   = 300;
    localparam int occ_bound = 60; // Cards alive at once, all lists together
    localparam int max_len   = 12;
    localparam int limit     = num_ops * (occ_bound + max_len + 20) + 1000;

    logic                   clock;
    logic                   rst;
    logic                   start;
    card_pkg::card_cmd_t    cmd;
    logic                   busy;
    logic                   done;
    card_pkg::card_result_t result;

    card_pkg::card_value_t vals [16][$];  // Reference list contents per head
    card_pkg::card_addr_t  slots [16][$]; // Heap slot of each model card
    bit                    occupied [`CARD_RAM_DEPTH];
    int                    total_cards;
    logic [31:0]           rng;
    int                    errors;
    int                    checks;
    int                    cycle;
    int                    accepted;
    int                    dones;
    card_pkg::card_addr_t  last_addr;
    card_pkg::card_value_t last_value;
    bit                    have_addr;
    bit                    have_value;

    card_list_top uut (
        .clock  (clock),
        .rst    (rst),
        .start  (start),
        .cmd    (cmd),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle);
            $display("Some tests failed");
            $finish;
        end
    end

    // Starts taken while idle against done pulses
    always @(negedge clock) begin
        if (!rst && start && !busy) begin
            accepted <= accepted + 1;
        end
        if (done) begin
            dones <= dones + 1;
        end
    end

    reset_quiet: assert property (@(posedge clock) (rst && cycle != 0) |-> (!busy && !done))
        else begin
            errors++;
            $display("Busy or done went high during reset");
        end
    done_after_busy: assert property (@(posedge clock) disable iff (rst) done |-> $fell(busy))
        else begin
            errors++;
            $display("Done pulsed without busy falling in the same cycle");
        end
    busy_ends_with_done: assert property (@(posedge clock) disable iff (rst) $fell(busy) |-> done)
        else begin
            errors++;
            $display("Busy fell without a done pulse");
        end
    busy_needs_start: assert property (@(posedge clock) disable iff (rst)
                                       $rose(busy) |-> $past(start))
        else begin
            errors++;
            $display("Busy rose with no start in the cycle before");
        end
    start_taken: assert property (@(posedge clock) disable iff (rst) (start && !busy) |=> busy)
        else begin
            errors++;
            $display("A start given while idle did not raise busy");
        end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // One command through the model and the DUT, optionally with a start pulsed while busy
    task automatic run_op(input card_pkg::card_op_t op, input card_pkg::card_addr_t head,
                          input card_pkg::card_value_t value, input card_pkg::card_index_t n,
                          input bit poke);
        card_pkg::card_addr_t  exp_addr;
        card_pkg::card_value_t exp_value;
        int                    slot;
        exp_addr  = '0;
        exp_value = '0;
        if (op == card_pkg::OP_ADD) begin
            slot = `CARD_HEAP_BASE;
            while (occupied[slot]) begin
                slot++;
            end
            occupied[slot] = 1'b1;
            exp_addr = card_pkg::card_addr_t'(slot); // Lowest free heap slot
            vals[head].push_back(value);
            slots[head].push_back(exp_addr);
            total_cards++;
        end else begin
            exp_value = vals[head][n];
            occupied[slots[head][n]] = 1'b0;
            vals[head].delete(n);
            slots[head].delete(n);
            total_cards--;
        end
        @(posedge clock);
        #1;
        start     = 1'b1;
        cmd.op    = op;
        cmd.head  = head;
        cmd.value = value;
        cmd.n     = n;
        @(posedge clock);
        #1;
        start = 1'b0;
        if (poke) begin
            cmd.op = card_pkg::OP_REMOVE; // Would break the model if taken
            cmd.n  = '0;
            start  = 1'b1;
            @(posedge clock);
            #1;
            start = 1'b0;
        end
        while (!done) begin
            @(posedge clock);
            #1;
        end
        checks++;
        if (op == card_pkg::OP_ADD) begin
            assert (result.new_addr == exp_addr) else begin
                errors++;
                $display("FAIL result.new_addr: got %h, expected %h", result.new_addr, exp_addr);
            end
            if (have_value) begin
                assert (result.removed_value == last_value) else begin
                    errors++;
                    $display("FAIL result.removed_value: got %h, expected %h",
                             result.removed_value, last_value);
                end
            end
            last_addr = exp_addr;
            have_addr = 1'b1;
        end else begin
            assert (result.removed_value == exp_value) else begin
                errors++;
                $display("FAIL result.removed_value: got %h, expected %h",
                         result.removed_value, exp_value);
            end
            if (have_addr) begin
                assert (result.new_addr == last_addr) else begin
                    errors++;
                    $display("FAIL result.new_addr: got %h, expected %h",
                             result.new_addr, last_addr);
                end
            end
            last_value = exp_value;
            have_value = 1'b1;
        end
    endtask

    task automatic random_ops(input int count);
        card_pkg::card_addr_t  head;
        card_pkg::card_value_t value;
        int                    len;
        bit                    poke;
        for (int i = 0; i < count; i++) begin
            rng   = xorshift(rng);
            head  = card_pkg::card_addr_t'(1 + rng[15:0] % 15);
            value = rng[21:16];
            poke  = (rng[31:29] == 3'b000);
            len   = vals[head].size();
            rng   = xorshift(rng);
            if (len == 0 || (len < max_len && total_cards < occ_bound && rng[0])) begin
                run_op(card_pkg::OP_ADD, head, value, '0, poke);
            end else begin
                run_op(card_pkg::OP_REMOVE, head, '0, card_pkg::card_index_t'(rng % len), poke);
            end
        end
    endtask

    initial begin
        clock       = 1'b0;
        rst         = 1'b1;
        start       = 1'b0;
        cmd         = '0;
        rng         = 32'h6189;
        errors      = 0;
        checks      = 0;
        cycle       = 0;
        accepted    = 0;
        dones       = 0;
        total_cards = 0;
        have_addr   = 1'b0;
        have_value  = 1'b0;
        repeat (3) @(posedge clock);
        #1;
        rst = 1'b0;
        repeat (5) @(posedge clock); // Idle, nothing may move

        // FIFO order on one list
        for (int i = 0; i < 6; i++) begin
            rng = xorshift(rng);
            run_op(card_pkg::OP_ADD, 1, rng[5:0], '0, i[0]);
        end
        for (int i = 0; i < 6; i++) begin
            run_op(card_pkg::OP_REMOVE, 1, '0, '0, i[0]);
        end
        for (int i = 0; i < 5; i++) begin
            rng = xorshift(rng);
            run_op(card_pkg::OP_ADD, 1, rng[5:0], '0, 1'b0);
            run_op(card_pkg::OP_REMOVE, 1, '0, '0, 1'b1);
        end

        // Random index removals down to an empty list
        for (int i = 0; i < 10; i++) begin
            rng = xorshift(rng);
            run_op(card_pkg::OP_ADD, 2, rng[5:0], '0, 1'b0);
        end
        while (vals[2].size() != 0) begin
            rng = xorshift(rng);
            run_op(card_pkg::OP_REMOVE, 2, '0,
                   card_pkg::card_index_t'(rng % vals[2].size()), rng[8]);
        end

        random_ops(240); // All heads mixed

        repeat (3) @(posedge clock);
        if (dones != accepted) begin
            errors++;
            $display("Saw %0d done pulses for %0d accepted starts", dones, accepted);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
